// ==== verilog/clusterPkg.sv ====
`default_nettype none

package clusterPkg;

	// Platform sizes
	localparam int numCores = 4;
	localparam int coreIdxWidth = 2;                       // Selects one of numCores
	localparam int r0Width = 16;
	localparam int tmDepth = 16;
	localparam int tmAddrWidth = 4;

	// APB sizes
	localparam int apbAddrWidth = 8;
	localparam int apbDataWidth = 32;

	// Register map, one 32-bit register per address step
	localparam logic [apbAddrWidth-1:0] regCtrl = 8'h00;
	localparam logic [apbAddrWidth-1:0] regResultBase = 8'h10; // One R0 per core
	localparam logic [apbAddrWidth-1:0] regTmBase = 8'h20;     // Low half at even address

	localparam logic [apbAddrWidth-1:0] resultRegCount = 8'(numCores);
	localparam logic [apbAddrWidth-1:0] tmRegCount = 8'(2 * tmDepth);

	// Control and status bits
	localparam int ctrlStartBit = 0;                       // Write side
	localparam int statRunningBit = 0;                     // Read side
	localparam int statDoneBit = 1;

endpackage

`default_nettype wire

// ==== verilog/taskPkg.sv ====
`default_nettype none

package taskPkg;

	localparam int wordWidth = 48;
	localparam int immWidth = 8;
	localparam int delayWidth = 4;
	localparam int initWidth = 8;                          // Initial R0 per core
	localparam int countWidth = 4;                         // Instruction frames per control frame
	localparam int fenceWidth = 2;
	localparam int ctrlPadWidth = wordWidth - countWidth - fenceWidth
		- 2 * clusterPkg::numCores - clusterPkg::numCores * initWidth;

	typedef enum logic [fenceWidth-1:0] {
		fenceNo = 2'd0,
		fenceAcq = 2'd1,                                   // Later frames wait for all cores
		fenceRel = 2'd2                                    // This frame waits for all cores
	} fenceT;

	typedef struct packed {
		logic [immWidth-1:0] imm;
		logic [delayWidth-1:0] delay;                      // Extra busy cycles
	} opT;

	// Frame count sits in the low bits of both frame kinds
	typedef struct packed {
		logic [ctrlPadWidth-1:0] pad;
		logic [clusterPkg::numCores-1:0][initWidth-1:0] initR0;
		logic [clusterPkg::numCores-1:0] r0Vect;
		logic [clusterPkg::numCores-1:0] activeVect;
		fenceT fence;
		logic [countWidth-1:0] frameCount;
	} ctrlFrameT;

	typedef struct packed {
		opT [clusterPkg::numCores-1:0] op;                 // Core 0 in the low bits
	} insnFrameT;

	typedef union packed {
		ctrlFrameT ctrl;
		insnFrameT insn;
	} taskWordT;

endpackage

`default_nettype wire

// ==== verilog/taskMemRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module taskMemRegs (
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [clusterPkg::apbAddrWidth-1:0] paddr,
	input wire [clusterPkg::apbDataWidth-1:0] pwdata,
	input wire [clusterPkg::tmAddrWidth-1:0] tmIndex,
	input wire running,
	input wire progDone,
	input wire [clusterPkg::numCores*clusterPkg::r0Width-1:0] coreR0,
	output logic [clusterPkg::apbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output taskPkg::taskWordT tmWord,
	output logic runPulse
);
	import clusterPkg::*;
	import taskPkg::*;

	localparam int hiWidth = wordWidth - apbDataWidth;

	logic [apbDataWidth-1:0] tmLo [tmDepth];
	logic [hiWidth-1:0] tmHi [tmDepth];
	logic access;
	logic writeAcc;
	logic [apbAddrWidth-1:0] tmOff;
	logic [apbAddrWidth-1:0] resOff;
	logic isCtrl;
	logic isTm;
	logic isRes;
	logic [tmAddrWidth-1:0] tmSel;
	logic [coreIdxWidth-1:0] resSel;
	logic tmBlocked;

	assign access = psel & penable;
	assign writeAcc = access & pwrite;
	assign tmOff = paddr - regTmBase;                      // Wraps high below the base
	assign resOff = paddr - regResultBase;
	assign isCtrl = (paddr == regCtrl);
	assign isTm = (tmOff < tmRegCount);
	assign isRes = (resOff < resultRegCount);
	assign tmSel = tmOff[tmAddrWidth:1];
	assign resSel = resOff[coreIdxWidth-1:0];
	assign tmBlocked = writeAcc & isTm & running;          // Program is live

	assign pready = 1'b1;
	assign pslverr = access & (~(isCtrl | isTm | isRes) | tmBlocked);

	assign tmWord = {tmHi[tmIndex], tmLo[tmIndex]};

	always_comb begin
		prdata = '0;
		if (isCtrl) begin
			prdata[statRunningBit] = running;
			prdata[statDoneBit] = progDone;
		end else if (isTm) begin
			prdata = tmOff[0] ? apbDataWidth'(tmHi[tmSel]) : tmLo[tmSel];
		end else if (isRes) begin
			prdata = apbDataWidth'(coreR0[resSel*r0Width +: r0Width]);
		end
	end

	always_ff @(posedge clk) begin
		if (writeAcc & isTm & ~running) begin
			if (tmOff[0])
				tmHi[tmSel] <= pwdata[hiWidth-1:0];
			else
				tmLo[tmSel] <= pwdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			runPulse <= 1'b0;
		else
			runPulse <= writeAcc & isCtrl & pwdata[ctrlStartBit];
	end

endmodule

`default_nettype wire

// ==== verilog/taskScheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module taskScheduler (
	input wire clk,
	input wire reset,
	input wire runPulse,
	input wire taskPkg::taskWordT tmWord,
	input wire [clusterPkg::numCores-1:0] ready,
	output logic [clusterPkg::tmAddrWidth-1:0] tmIndex,
	output logic running,
	output logic progDone,
	output logic [clusterPkg::numCores-1:0] start,
	output taskPkg::insnFrameT insnWord,
	output logic [clusterPkg::numCores-1:0] initR0Vect,
	output logic [clusterPkg::numCores*taskPkg::initWidth-1:0] initR0
);
	import clusterPkg::*;
	import taskPkg::*;

	ctrlFrameT ctrl;
	logic [countWidth-1:0] frameCnt;                       // Instruction frames left
	fenceT fence;
	logic [numCores-1:0] activeVect;
	logic issued;                                          // Start sent for current frame
	logic allReady;
	logic nextReady;
	logic activeReady;
	logic isEnd;
	logic fenceOk;
	logic accept;
	logic issue;
	logic frameDone;

	assign ctrl = tmWord.ctrl;
	assign allReady = &ready;
	assign nextReady = ((ctrl.activeVect & ~ready) == '0);
	assign activeReady = ((activeVect & ~ready) == '0);
	assign isEnd = (ctrl.activeVect == '0) && (ctrl.frameCount == '0);

	always_comb begin
		if (isEnd)
			fenceOk = allReady;                            // Drain before done
		else if (fence == fenceAcq || ctrl.fence == fenceRel)
			fenceOk = allReady;
		else
			fenceOk = nextReady;                           // Only this frame's cores
	end

	assign accept = running && (frameCnt == '0) && fenceOk;
	assign issue = running && (frameCnt != '0) && !issued;
	// Start already cleared, so ready now reflects the new work
	assign frameDone = running && (frameCnt != '0) && issued && (start == '0)
		&& (activeReady || frameCnt == countWidth'(1));    // Last frame leaves cores busy

	always_ff @(posedge clk) begin
		if (reset) begin
			tmIndex <= '0;
			frameCnt <= '0;
			fence <= fenceNo;
			activeVect <= '0;
			issued <= 1'b0;
			running <= 1'b0;
			progDone <= 1'b0;
			start <= '0;
			initR0Vect <= '0;
		end else if (runPulse) begin
			tmIndex <= '0;
			frameCnt <= '0;
			fence <= fenceNo;
			issued <= 1'b0;
			running <= 1'b1;
			progDone <= 1'b0;
			start <= '0;
			initR0Vect <= '0;
		end else begin
			start <= '0;                                   // Pulses by default
			initR0Vect <= '0;
			if (accept) begin
				if (isEnd) begin
					running <= 1'b0;
					progDone <= 1'b1;
				end else begin
					tmIndex <= tmIndex + 1'b1;
					frameCnt <= ctrl.frameCount;
					fence <= ctrl.fence;
					activeVect <= ctrl.activeVect;
					initR0Vect <= ctrl.r0Vect;
				end
			end else if (issue) begin
				start <= activeVect;
				issued <= 1'b1;
			end else if (frameDone) begin
				tmIndex <= tmIndex + 1'b1;
				frameCnt <= frameCnt - 1'b1;
				issued <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			initR0 <= ctrl.initR0;
		if (issue)
			insnWord <= tmWord.insn;
	end

endmodule

`default_nettype wire

// ==== verilog/accumCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module accumCore (
	input wire clk,
	input wire reset,
	input wire start,
	input wire taskPkg::opT op,
	input wire initR0Load,
	input wire [taskPkg::initWidth-1:0] initR0Val,
	output logic ready,
	output logic [clusterPkg::r0Width-1:0] r0
);
	import clusterPkg::*;
	import taskPkg::*;

	logic [delayWidth-1:0] count;
	logic [immWidth-1:0] imm;
	logic finish;

	assign finish = !ready && (count == '0);               // Last busy cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			ready <= 1'b1;
			count <= '0;
		end else if (start && ready) begin
			ready <= 1'b0;
			count <= op.delay;
		end else if (finish) begin
			ready <= 1'b1;
		end else if (!ready) begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start && ready)
			imm <= op.imm;
	end

	// An init load on the same edge wins over the add
	always_ff @(posedge clk) begin
		if (reset)
			r0 <= '0;
		else if (initR0Load)
			r0 <= r0Width'(initR0Val);
		else if (finish)
			r0 <= r0 + r0Width'(imm);                      // Wraps at 2^16
	end

endmodule

`default_nettype wire

// ==== verilog/coreCluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreCluster (
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [clusterPkg::apbAddrWidth-1:0] paddr,
	input wire [clusterPkg::apbDataWidth-1:0] pwdata,
	output wire [clusterPkg::apbDataWidth-1:0] prdata,
	output wire pready,
	output wire pslverr,
	output wire done
);
	import clusterPkg::*;
	import taskPkg::*;

	taskWordT tmWord;
	insnFrameT insnWord;
	logic [tmAddrWidth-1:0] tmIndex;
	logic runPulse;
	logic running;
	logic [numCores-1:0] start;
	logic [numCores-1:0] ready;
	logic [numCores-1:0] initR0Vect;
	logic [numCores*initWidth-1:0] initR0;
	logic [numCores*r0Width-1:0] coreR0;

	taskMemRegs regs (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.tmIndex(tmIndex), .running(running), .progDone(done), .coreR0(coreR0),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.tmWord(tmWord), .runPulse(runPulse)
	);

	taskScheduler sched (
		.clk(clk), .reset(reset), .runPulse(runPulse), .tmWord(tmWord), .ready(ready),
		.tmIndex(tmIndex), .running(running), .progDone(done),
		.start(start), .insnWord(insnWord), .initR0Vect(initR0Vect), .initR0(initR0)
	);

	for (genvar i = 0; i < numCores; i++) begin : coreGen
		accumCore core (
			.clk(clk),
			.reset(reset),
			.start(start[i]),
			.op(insnWord.op[i]),                           // This core's slot
			.initR0Load(initR0Vect[i]),
			.initR0Val(initR0[i*initWidth +: initWidth]),
			.ready(ready[i]),
			.r0(coreR0[i*r0Width +: r0Width])
		);
	end

endmodule

`default_nettype wire

// ==== testbench/clusterTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module clusterTb;
	import clusterPkg::*;
	import taskPkg::*;

	localparam int numProgs = 10;
	localparam int frameCycles = 2 ** delayWidth + 4;       // Longest busy time plus dispatch
	localparam int apbCycles = 3 * (2 * tmDepth + numCores + 16);
	localparam int watchdogCycles = numProgs * (tmDepth * frameCycles + apbCycles) + 100;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apbAddrWidth-1:0] paddr;
	logic [apbDataWidth-1:0] pwdata;
	wire [apbDataWidth-1:0] prdata;
	wire pready;
	wire pslverr;
	wire done;

	taskWordT prog [tmDepth];
	int progLen;
	logic [15:0] lfsr;
	logic [numCores*r0Width-1:0] model;                    // Expected R0, kept across runs
	logic [apbDataWidth-1:0] rdata;
	logic err;
	int errCount;
	int testCount;
	int testFails;
	int testStartErrs;

	coreCluster uut (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#(watchdogCycles * 100);
		$display("timeout: no result after %0d cycles", watchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16 + x^14 + x^13 + x^11 + 1
			lfsr = {lfsr[14:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	// Program order model of the cluster
	function automatic logic [numCores*r0Width-1:0] refModel(
			input logic [numCores*r0Width-1:0] prior);
		logic [numCores*r0Width-1:0] r;
		ctrlFrameT c;
		insnFrameT w;
		int idx;
		r = prior;
		idx = 0;
		while (idx < progLen) begin
			c = prog[idx].ctrl;
			idx++;
			if (c.activeVect == '0 && c.frameCount == '0)
				break;
			for (int k = 0; k < numCores; k++)
				if (c.r0Vect[k])
					r[k*r0Width +: r0Width] = r0Width'(c.initR0[k]);
			for (int f = 0; f < int'(c.frameCount); f++) begin
				w = prog[idx].insn;
				idx++;
				for (int k = 0; k < numCores; k++)
					if (c.activeVect[k])
						r[k*r0Width +: r0Width] = r[k*r0Width +: r0Width] + r0Width'(w.op[k].imm);
			end
		end
		return r;
	endfunction

	task automatic checkR0(input string name, input int core,
			input logic [r0Width-1:0] exp, input logic [r0Width-1:0] act);
		if (act !== exp) begin
			$display("error %s: core %0d R0 expected %h actual %h", name, core, exp, act);
			errCount++;
		end
	endtask

	task automatic checkStatus(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("error %s: status expected %b actual %b", name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkErr(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error %s: pslverr expected %b actual %b", name, exp, act);
			errCount++;
		end
	endtask

	task automatic apbXfer(input logic wr, input logic [apbAddrWidth-1:0] addr,
			input logic [apbDataWidth-1:0] wdata, output logic [apbDataWidth-1:0] rd,
			output logic slvErr);
		int waitCnt;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		waitCnt = 0;
		@(negedge clk);
		while (!pready && waitCnt < 16) begin
			@(negedge clk);
			waitCnt++;
		end
		if (!pready) begin
			$display("APB transfer to address %h never completed", addr);
			errCount++;
		end
		rd = prdata;
		slvErr = pslverr;
		@(posedge clk);                                    // Access phase ends here
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic waitDone(input string name, input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (done !== level && cycles < tmDepth * frameCycles) begin
			@(negedge clk);
			cycles++;
		end
		if (done !== level) begin
			$display("%s: done did not reach %b in time", name, level);
			errCount++;
		end
	endtask

	task automatic addCtrl(input logic [countWidth-1:0] count, input fenceT fence,
			input logic [numCores-1:0] active, input logic [numCores-1:0] r0v,
			input logic [numCores*initWidth-1:0] init);
		ctrlFrameT c;
		c = '0;
		c.frameCount = count;
		c.fence = fence;
		c.activeVect = active;
		c.r0Vect = r0v;
		c.initR0 = init;
		prog[progLen].ctrl = c;
		progLen++;
	endtask

	task automatic addInsn(input logic [numCores*immWidth-1:0] imms,
			input logic [numCores*delayWidth-1:0] delays);
		insnFrameT w;
		for (int k = 0; k < numCores; k++) begin
			w.op[k].imm = imms[k*immWidth +: immWidth];
			w.op[k].delay = delays[k*delayWidth +: delayWidth];
		end
		prog[progLen].insn = w;
		progLen++;
	endtask

	task automatic genProg();
		logic [countWidth-1:0] count;
		fenceT fence;
		fenceT prevFence;
		logic [numCores-1:0] active;
		logic [numCores-1:0] r0v;
		progLen = 0;
		prevFence = fenceNo;
		count = countWidth'(takeBits(2) + 1);
		while (progLen + int'(count) + 2 <= tmDepth) begin
			active = numCores'(takeBits(numCores));
			if (active == '0)
				active = 4'b0001;
			fence = fenceT'(fenceWidth'(takeBits(fenceWidth)));
			if (fence != fenceAcq && fence != fenceRel)
				fence = fenceNo;
			r0v = numCores'(takeBits(numCores));
			if (prevFence != fenceAcq && fence != fenceRel)
				r0v = r0v & active;                        // Only this frame's cores are idle
			addCtrl(count, fence, active, r0v, takeBits(32));
			for (int f = 0; f < int'(count); f++)
				addInsn(takeBits(32), 16'(takeBits(16)));
			prevFence = fence;
			count = countWidth'(takeBits(2) + 1);
		end
		addCtrl('0, fenceNo, '0, '0, '0);                  // End frame
	endtask

	task automatic loadProg(input string name);
		for (int i = 0; i < progLen; i++) begin
			apbXfer(1'b1, regTmBase + apbAddrWidth'(2 * i), prog[i][apbDataWidth-1:0], rdata, err);
			checkErr(name, 1'b0, err);
			apbXfer(1'b1, regTmBase + apbAddrWidth'(2 * i + 1),
				apbDataWidth'(prog[i][wordWidth-1:apbDataWidth]), rdata, err);
			checkErr(name, 1'b0, err);
		end
	endtask

	task automatic checkResults(input string name, input logic [1:0] expStatus);
		apbXfer(1'b0, regCtrl, '0, rdata, err);
		checkStatus(name, expStatus, {rdata[statDoneBit], rdata[statRunningBit]});
		for (int c = 0; c < numCores; c++) begin
			apbXfer(1'b0, regResultBase + apbAddrWidth'(c), '0, rdata, err);
			checkR0(name, c, model[c*r0Width +: r0Width], rdata[r0Width-1:0]);
		end
	endtask

	task automatic runProg(input string name);
		loadProg(name);
		model = refModel(model);
		apbXfer(1'b1, regCtrl, 32'h1, rdata, err);
		waitDone(name, 1'b0);
		waitDone(name, 1'b1);
		checkResults(name, 2'b10);
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errCount == testStartErrs) begin
			$display("test %s passed", name);
		end else begin
			testFails++;
			$display("test %s failed with %0d errors", name, errCount - testStartErrs);
		end
		testStartErrs = errCount;
	endtask

	initial begin
		int polls;
		string name;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		reset <= 1'b1;
		lfsr = 16'd16163;
		model = '0;
		errCount = 0;
		testCount = 0;
		testFails = 0;
		testStartErrs = 0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		checkResults("resetState", 2'b00);
		apbXfer(1'b0, 8'h08, '0, rdata, err);              // Hole in the map
		checkErr("resetState", 1'b1, err);
		endTest("resetState");

		progLen = 0;
		addCtrl(4'd2, fenceNo, 4'hF, 4'hF, 32'h4030_2010);
		addInsn(32'h0403_0201, 16'h0000);
		addInsn(32'h8070_6050, 16'h1234);
		addCtrl('0, fenceNo, '0, '0, '0);
		runProg("singleFrame");
		endTest("singleFrame");

		progLen = 0;
		addCtrl(4'd2, fenceAcq, 4'hF, 4'hF, 32'h0102_0304);
		addInsn(32'h1122_3344, 16'hF31A);
		addInsn(32'h55AA_FF01, 16'h0F50);
		addCtrl(4'd1, fenceRel, 4'b0101, 4'b1010, 32'h8888_7777);
		addInsn(32'h0909_0909, 16'h2E07);
		addCtrl(4'd1, fenceNo, 4'b0011, 4'b0001, 32'h0000_00C0);
		addInsn(32'hEEDD_CCBB, 16'hD0C3);
		addCtrl('0, fenceNo, '0, '0, '0);
		runProg("fences");
		endTest("fences");

		progLen = 0;
		addCtrl(4'd1, fenceNo, 4'b0010, 4'b0010, 32'h0000_5500);
		addInsn(32'h0000_2200, 16'h00F0);                  // Core 1 stays busy
		addCtrl(4'd2, fenceNo, 4'b1100, 4'b1000, 32'hA000_0000);
		addInsn(32'h3344_0000, 16'h1200);
		addInsn(32'h0102_0000, 16'h3400);
		addCtrl('0, fenceNo, '0, '0, '0);
		runProg("partialVect");
		endTest("partialVect");

		progLen = 0;
		addCtrl(4'd3, fenceNo, 4'hF, 4'h0, '0);
		addInsn(32'h0101_0101, 16'hFFFF);
		addInsn(32'h1020_3040, 16'hFFFF);
		addInsn(32'h0F0E_0D0C, 16'hFFFF);
		addCtrl('0, fenceNo, '0, '0, '0);
		loadProg("busyWrite");
		model = refModel(model);
		apbXfer(1'b1, regCtrl, 32'h1, rdata, err);
		rdata = '0;
		polls = 0;
		while (!rdata[statRunningBit] && polls < 8) begin
			apbXfer(1'b0, regCtrl, '0, rdata, err);
			polls++;
		end
		apbXfer(1'b1, regTmBase + 8'd6, '1, rdata, err);   // Last frame, not yet fetched
		checkErr("busyWrite", 1'b1, err);
		waitDone("busyWrite", 1'b0);
		waitDone("busyWrite", 1'b1);
		checkResults("busyWrite", 2'b10);
		endTest("busyWrite");

		for (int p = 0; p < 5; p++) begin
			name = $sformatf("lfsrProg%0d", p);
			genProg();
			runProg(name);
			endTest(name);
		end

		$display("%0d tests run, %0d failed, %0d errors", testCount, testFails, errCount);
		if (errCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/clusterPkg.sv
verilog/taskPkg.sv
verilog/taskMemRegs.sv
verilog/taskScheduler.sv
verilog/accumCore.sv
verilog/coreCluster.sv
testbench/clusterTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module clusterTb -f src.f -o clusterSim
./obj_dir/clusterSim > sim.log 2>&1
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
